// File: project.f
+incdir+hw
hw/mpu_pkg.sv
hw/pma_lookup.sv
hw/mpu_core.sv
hw/obi_master.sv
hw/mpu_top.sv
tests/tb_mpu_top.sv

// File: run.sh
#!/bin/sh
# Build the MPU testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_mpu_top \
  -o tb_mpu_top

./obj_dir/tb_mpu_top | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: tests/tb_mpu_top.sv
// Testbench for the data-side MPU top level
// OBI memory model, directed and random stimulus, checks on the core and OBI ports
`timescale 1ns/1ps
`default_nettype none
`include "mpu_settings.svh"

module tb_mpu_top;
  import mpu_pkg::*;

  localparam logic [31:0] RDATA_MASK     = 32'h5a5a_5a5a;
  localparam int          ACCEPT_TIMEOUT = 50;
  localparam int          DRAIN_TIMEOUT  = 200;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        core_trans_valid_i = 1'b0;
  core_trans_t core_trans_i = '0;
  logic        core_trans_ready_o;
  logic        core_resp_valid_o;
  core_resp_t  core_resp_o;
  logic        obi_req_o;
  logic [31:0] obi_addr_o;
  logic        obi_we_o;
  logic [3:0]  obi_be_o;
  logic [31:0] obi_wdata_o;
  logic [1:0]  obi_memtype_o;
  logic        obi_gnt_i = 1'b0;
  logic        obi_rvalid_i = 1'b0;
  logic [31:0] obi_rdata_i = '0;
  logic        obi_err_i = 1'b0;

  integer      seed = 32'h37c2_ebd2;
  string       test_name = "reset";
  int          cycle = 0;
  int          err_due_cycle = -1;
  logic        slow_rsp = 1'b0;
  logic        grant_seen = 1'b0;
  logic [31:0] grant_addr = '0;
  core_resp_t  exp_q[$];
  logic [31:0] rsp_addr_q[$];
  int          rsp_due_q[$];

  mpu_top dut0 (.*);

  always #50 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    abort_run($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                        test_name, what, expected, actual));
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  // The memory flags a bus error for every word with address bit 3 set
  function automatic logic mem_bus_err(input logic [31:0] addr);
    return addr[3];
  endfunction

  // Region attributes {main, bufferable, cacheable, atomic}, lowest index wins
  function automatic logic [3:0] region_attr(input logic [31:0] addr);
    logic [29:0] w;
    w = addr[31:2];
    if (w >= `MPU_REGION_0_LOW && w < `MPU_REGION_0_HIGH) begin
      return `MPU_REGION_0_ATTR;
    end
    if (w >= `MPU_REGION_1_LOW && w < `MPU_REGION_1_HIGH) begin
      return `MPU_REGION_1_ATTR;
    end
    if (w >= `MPU_REGION_2_LOW && w < `MPU_REGION_2_HIGH) begin
      return `MPU_REGION_2_ATTR;
    end
    if (w >= `MPU_REGION_3_LOW && w < `MPU_REGION_3_HIGH) begin
      return `MPU_REGION_3_ATTR;
    end
    return 4'b0000;
  endfunction

  function automatic logic access_denied(input core_trans_t t);
    logic [3:0] attr;
    attr = region_attr(t.addr);
    return ((t.execute || t.misaligned) && !attr[3]) || (t.atomic && !attr[0]);
  endfunction

  function automatic core_trans_t make_trans(input logic [31:0] addr, input logic atomic,
                                             input logic execute, input logic misaligned);
    core_trans_t t;
    t.addr       = addr;
    t.we         = 1'b0;
    t.wdata      = ~addr;
    t.be         = 4'hf;
    t.atomic     = atomic;
    t.execute    = execute;
    t.misaligned = misaligned;
    return t;
  endfunction

  // Bases cover every region, the overlap and two unmapped holes
  function automatic core_trans_t random_trans();
    core_trans_t t;
    logic [31:0] base;
    case (rand_range(0, 6))
      0:       base = 32'h0000_0000;
      1:       base = 32'h0000_1000;
      2:       base = 32'h0000_3000;
      3:       base = 32'h0001_0000;
      4:       base = 32'h2000_0000;
      5:       base = 32'h0000_4000;
      default: base = 32'h8000_0000;
    endcase
    t.misaligned = (rand_range(0, 5) == 0);
    t.atomic     = (rand_range(0, 5) == 0);
    t.execute    = (rand_range(0, 5) == 0);
    t.we         = (rand_range(0, 1) == 1);
    t.be         = 4'(rand_range(1, 15));
    t.wdata      = $random(seed);
    t.addr       = base + 32'(rand_range(0, 1023) * 4);
    if (t.misaligned) begin
      t.addr[1:0] = 2'b10;
    end
    return t;
  endfunction

  // Holds the transaction until the DUT takes it
  task automatic send(input core_trans_t t);
    int waited;
    waited = 0;
    @(posedge clk);
    core_trans_valid_i <= 1'b1;
    core_trans_i       <= t;
    @(negedge clk);
    while (!core_trans_ready_o) begin
      waited++;
      if (waited > ACCEPT_TIMEOUT) begin
        abort_run($sformatf("%s: transaction not accepted in time", test_name));
      end
      @(negedge clk);
    end
  endtask

  task automatic stop_core();
    @(posedge clk);
    core_trans_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        abort_run($sformatf("%s: responses missing at the core port", test_name));
      end
      @(posedge clk);
    end
  endtask

  ////////////////////
  // OBI memory model
  ////////////////////

  always @(negedge clk) begin
    grant_seen = obi_req_o && obi_gnt_i;
    grant_addr = obi_addr_o;
  end

  always @(posedge clk) begin : mem_model
    int          due;
    int          delay;
    int          gnt_wait;
    logic [31:0] head_addr;
    cycle <= cycle + 1;
    if (!rst_n) begin
      obi_gnt_i    <= 1'b0;
      obi_rvalid_i <= 1'b0;
      gnt_wait     = 1;
      due          = 0;
    end else begin
      // rvalid 1 to 3 cycles after the grant, never before the previous one
      if (grant_seen) begin
        delay = slow_rsp ? 2 : rand_range(0, 2);
        due = (cycle + delay > due) ? cycle + delay : due + 1;
        rsp_addr_q.push_back(grant_addr);
        rsp_due_q.push_back(due);
        gnt_wait = rand_range(0, 2);
        if (gnt_wait > 0) begin
          obi_gnt_i <= 1'b0;
        end
      end else if (gnt_wait > 0) begin
        gnt_wait--;
        if (gnt_wait == 0) begin
          obi_gnt_i <= 1'b1;
        end
      end
      obi_rvalid_i <= 1'b0;
      if (rsp_due_q.size() > 0) begin
        if (rsp_due_q[0] <= cycle) begin
          head_addr = rsp_addr_q.pop_front();
          rsp_due_q.delete(0);
          obi_rvalid_i <= 1'b1;
          obi_rdata_i  <= head_addr ^ RDATA_MASK;
          obi_err_i    <= mem_bus_err(head_addr);
        end
      end
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(negedge clk) begin : monitor
    core_resp_t head;
    core_resp_t entry;
    int         pending;
    logic [3:0] attr;
    logic [1:0] exp_memtype;
    if (rst_n) begin
      pending = exp_q.size();
      if (core_resp_valid_o) begin
        assert (pending > 0)
          else abort_run($sformatf("%s: response without an issued transaction", test_name));
        head = exp_q.pop_front();
        assert (core_resp_o.mpu_status == head.mpu_status)
          else report_mismatch("status", 64'(head.mpu_status), 64'(core_resp_o.mpu_status));
        assert (core_resp_o.bus_err == head.bus_err)
          else report_mismatch("bus error", 64'(head.bus_err), 64'(core_resp_o.bus_err));
        if (head.mpu_status == MPU_OK) begin
          assert (core_resp_o.rdata == head.rdata)
            else report_mismatch("read data", 64'(head.rdata), 64'(core_resp_o.rdata));
        end else if (err_due_cycle >= 0) begin
          assert (cycle == err_due_cycle)
            else report_mismatch("error response cycle", 64'(err_due_cycle), 64'(cycle));
          err_due_cycle = -1;
        end
      end

      // Only allowed transactions reach the bus, with the region memtype
      if (obi_req_o) begin
        assert (core_trans_valid_i && !access_denied(core_trans_i))
          else abort_run($sformatf("%s: OBI request for a blocked access", test_name));
        if (obi_gnt_i) begin
          attr        = region_attr(core_trans_i.addr);
          exp_memtype = {attr[1], attr[2]};
          assert (core_trans_ready_o)
            else abort_run($sformatf("%s: grant without core acceptance", test_name));
          assert (obi_addr_o == core_trans_i.addr)
            else report_mismatch("OBI address", 64'(core_trans_i.addr), 64'(obi_addr_o));
          assert (obi_memtype_o == exp_memtype)
            else report_mismatch("OBI memtype", 64'(exp_memtype), 64'(obi_memtype_o));
          assert ({obi_we_o, obi_be_o, obi_wdata_o} ==
                  {core_trans_i.we, core_trans_i.be, core_trans_i.wdata})
            else report_mismatch("OBI write fields", 64'(core_trans_i.wdata), 64'(obi_wdata_o));
        end
      end

      if (core_trans_valid_i && core_trans_ready_o) begin
        entry.rdata   = core_trans_i.addr ^ RDATA_MASK;
        entry.bus_err = 1'b0;
        if (access_denied(core_trans_i)) begin
          entry.mpu_status = MPU_ERR;
          // With nothing pending the error answer is due in the next cycle
          if (pending == 0) begin
            err_due_cycle = cycle + 1;
          end
        end else begin
          entry.mpu_status = MPU_OK;
          entry.bus_err    = mem_bus_err(core_trans_i.addr);
          assert (obi_req_o && obi_gnt_i)
            else abort_run($sformatf("%s: allowed access accepted without grant", test_name));
        end
        exp_q.push_back(entry);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    int n;
    int gap;
    @(posedge clk);
    @(negedge clk);
    assert (!obi_req_o && !core_resp_valid_o && !core_trans_ready_o &&
            dut0.u_mpu_core.state_q == MPU_IDLE)
      else abort_run("DUT outputs or FSM state wrong during reset");
    @(posedge clk);
    rst_n <= 1'b1;

    test_name = "aligned_read";
    send(make_trans(32'h0000_0100, 1'b0, 1'b0, 1'b0));
    send(make_trans(32'h2000_0040, 1'b0, 1'b0, 1'b0));
    stop_core();
    wait_drain();

    test_name = "execute_unmapped";
    send(make_trans(32'h8000_0000, 1'b0, 1'b1, 1'b0));
    stop_core();
    wait_drain();

    test_name = "atomic_misaligned";
    send(make_trans(32'h0000_3000, 1'b1, 1'b0, 1'b0));
    send(make_trans(32'h0001_0002, 1'b0, 1'b0, 1'b1));
    send(make_trans(32'h2000_0100, 1'b1, 1'b0, 1'b0));
    send(make_trans(32'h2000_0102, 1'b0, 1'b0, 1'b1));
    send(make_trans(32'h0000_0200, 1'b1, 1'b0, 1'b0));
    stop_core();
    wait_drain();

    test_name = "overlap";
    send(make_trans(32'h0000_1800, 1'b0, 1'b0, 1'b0));
    send(make_trans(32'h0000_2800, 1'b0, 1'b0, 1'b0));
    stop_core();
    wait_drain();

    // Slow responses keep both reads pending when the denied access arrives
    test_name = "error_order";
    slow_rsp <= 1'b1;
    send(make_trans(32'h0000_0040, 1'b0, 1'b0, 1'b0));
    send(make_trans(32'h0000_3004, 1'b0, 1'b0, 1'b0));
    send(make_trans(32'h8000_0010, 1'b0, 1'b1, 1'b0));
    stop_core();
    wait_drain();
    slow_rsp <= 1'b0;

    test_name = "random";
    for (n = 0; n < 200; n++) begin
      send(random_trans());
      gap = rand_range(0, 3);
      if (gap > 0) begin
        stop_core();
        repeat (gap - 1) @(posedge clk);
      end
    end
    stop_core();
    wait_drain();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mpu_top.sv
// Top level of the data-side MPU
// Region lookup, MPU control and OBI master
`timescale 1ns/1ps
`default_nettype none

module mpu_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core side
  input  logic                 core_trans_valid_i,
  input  mpu_pkg::core_trans_t core_trans_i,
  output logic                 core_trans_ready_o,
  output logic                 core_resp_valid_o,
  output mpu_pkg::core_resp_t  core_resp_o,

  // OBI side
  output logic                 obi_req_o,
  output logic [31:0]          obi_addr_o,
  output logic                 obi_we_o,
  output logic [3:0]           obi_be_o,
  output logic [31:0]          obi_wdata_o,
  output logic [1:0]           obi_memtype_o,
  input  logic                 obi_gnt_i,
  input  logic                 obi_rvalid_i,
  input  logic [31:0]          obi_rdata_i,
  input  logic                 obi_err_i
);
  import mpu_pkg::*;

  pma_region_t pma_cfg;
  logic        pma_err;
  logic        bus_trans_valid;
  bus_trans_t  bus_trans;
  logic        bus_trans_ready;
  logic        bus_resp_valid;
  bus_resp_t   bus_resp;
  logic        bus_idle;

  pma_lookup u_pma_lookup (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (core_trans_i.addr),
    .atomic_i     (core_trans_i.atomic),
    .execute_i    (core_trans_i.execute),
    .misaligned_i (core_trans_i.misaligned),
    .pma_cfg_o    (pma_cfg),
    .pma_err_o    (pma_err)
  );

  mpu_core u_mpu_core (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_i       (core_trans_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .pma_cfg_i          (pma_cfg),
    .pma_err_i          (pma_err),
    .bus_trans_valid_o  (bus_trans_valid),
    .bus_trans_o        (bus_trans),
    .bus_trans_ready_i  (bus_trans_ready),
    .bus_resp_valid_i   (bus_resp_valid),
    .bus_resp_i         (bus_resp),
    .bus_idle_i         (bus_idle)
  );

  obi_master u_obi_master (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_trans_valid_i (bus_trans_valid),
    .bus_trans_i       (bus_trans),
    .bus_trans_ready_o (bus_trans_ready),
    .bus_resp_valid_o  (bus_resp_valid),
    .bus_resp_o        (bus_resp),
    .bus_idle_o        (bus_idle),
    .obi_req_o         (obi_req_o),
    .obi_addr_o        (obi_addr_o),
    .obi_we_o          (obi_we_o),
    .obi_be_o          (obi_be_o),
    .obi_wdata_o       (obi_wdata_o),
    .obi_memtype_o     (obi_memtype_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_rdata_i       (obi_rdata_i),
    .obi_err_i         (obi_err_i)
  );

endmodule

`default_nettype wire

// File: hw/obi_master.sv
// OBI master for the data-side MPU
// Issues requests, tracks outstanding responses and returns read data
`timescale 1ns/1ps
`default_nettype none
`include "mpu_settings.svh"

module obi_master (
  input  logic                clk,
  input  logic                rst_n,

  // From the MPU control
  input  logic                bus_trans_valid_i,
  input  mpu_pkg::bus_trans_t bus_trans_i,
  output logic                bus_trans_ready_o,
  output logic                bus_resp_valid_o,
  output mpu_pkg::bus_resp_t  bus_resp_o,
  output logic                bus_idle_o,

  // OBI
  output logic                obi_req_o,
  output logic [31:0]         obi_addr_o,
  output logic                obi_we_o,
  output logic [3:0]          obi_be_o,
  output logic [31:0]         obi_wdata_o,
  output logic [1:0]          obi_memtype_o,
  input  logic                obi_gnt_i,
  input  logic                obi_rvalid_i,
  input  logic [31:0]         obi_rdata_i,
  input  logic                obi_err_i
);
  import mpu_pkg::*;

  localparam int unsigned MAX_OUT = `MPU_MAX_OUTSTANDING;
  localparam int          CNT_W   = $clog2(MAX_OUT + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             has_room;
  logic             obi_grant;

  assign has_room  = (cnt_q < CNT_W'(MAX_OUT));
  assign obi_grant = obi_req_o && obi_gnt_i;

  // Address phase
  assign obi_req_o         = bus_trans_valid_i && has_room;
  assign bus_trans_ready_o = obi_gnt_i && has_room;
  assign obi_addr_o        = bus_trans_i.addr;
  assign obi_we_o          = bus_trans_i.we;
  assign obi_be_o          = bus_trans_i.be;
  assign obi_wdata_o       = bus_trans_i.wdata;
  assign obi_memtype_o     = bus_trans_i.memtype;

  // Response phase
  assign bus_resp_valid_o = obi_rvalid_i;
  assign bus_resp_o.rdata = obi_rdata_i;
  assign bus_resp_o.err   = obi_err_i;
  assign bus_idle_o       = (cnt_q == '0);

  // Grants in, rvalids out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({obi_grant, obi_rvalid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_o && !obi_gnt_i) |=>
      (obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o) && $stable(obi_be_o) &&
       $stable(obi_wdata_o) && $stable(obi_memtype_o)))
    else $error("OBI address phase changed before grant");

  a_no_stray_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> (cnt_q != '0))
    else $error("OBI rvalid without an outstanding request");

  a_cnt_limit : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_W'(MAX_OUT))
    else $error("Outstanding count above the limit");

endmodule

`default_nettype wire

// File: hw/mpu_core.sv
// MPU control between the core port and the OBI master
// Forwards allowed transactions and sequences error responses in order
`timescale 1ns/1ps
`default_nettype none

module mpu_core (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core transaction port
  input  logic                 core_trans_valid_i,
  input  mpu_pkg::core_trans_t core_trans_i,
  output logic                 core_trans_ready_o,
  output logic                 core_resp_valid_o,
  output mpu_pkg::core_resp_t  core_resp_o,

  // Region lookup result
  input  mpu_pkg::pma_region_t pma_cfg_i,
  input  logic                 pma_err_i,

  // Towards the OBI master
  output logic                 bus_trans_valid_o,
  output mpu_pkg::bus_trans_t  bus_trans_o,
  input  logic                 bus_trans_ready_i,
  input  logic                 bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t   bus_resp_i,
  input  logic                 bus_idle_i
);
  import mpu_pkg::*;

  mpu_state_e state_q;
  mpu_state_e state_d;
  logic       core_accept;
  logic       err_trans_valid;

  assign core_accept     = core_trans_valid_i && core_trans_ready_o;
  assign err_trans_valid = (state_q == MPU_ERR_RESP);

  // Address phase goes straight through, memtype from the region
  always_comb begin
    bus_trans_o.addr    = core_trans_i.addr;
    bus_trans_o.we      = core_trans_i.we;
    bus_trans_o.wdata   = core_trans_i.wdata;
    bus_trans_o.be      = core_trans_i.be;
    bus_trans_o.memtype = {pma_cfg_i.cacheable, pma_cfg_i.bufferable};
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d            = state_q;
    bus_trans_valid_o  = 1'b0;
    core_trans_ready_o = 1'b0;

    case (state_q)
      MPU_IDLE: begin
        if (core_trans_valid_i) begin
          if (pma_err_i) begin
            // Take the denied access and keep it off the bus
            core_trans_ready_o = 1'b1;
            state_d = bus_idle_i ? MPU_ERR_RESP : MPU_WAIT_BUS;
          end else begin
            bus_trans_valid_o  = 1'b1;
            core_trans_ready_o = bus_trans_ready_i;
          end
        end
      end

      // Earlier bus responses drain first
      MPU_WAIT_BUS: begin
        if (bus_idle_i) begin
          state_d = MPU_ERR_RESP;
        end
      end

      MPU_ERR_RESP: begin
        state_d = MPU_IDLE;
      end

      default: begin
        state_d = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Response mux
  ////////////////////

  always_comb begin
    core_resp_valid_o      = bus_resp_valid_i || err_trans_valid;
    core_resp_o.rdata      = err_trans_valid ? 32'h0 : bus_resp_i.rdata;
    core_resp_o.bus_err    = bus_resp_i.err && !err_trans_valid;
    core_resp_o.mpu_status = err_trans_valid ? MPU_ERR : MPU_OK;
  end

  ////////////////////
  // Assertions
  ////////////////////

  // The bus side must be drained before the error slot
  a_no_bus_resp_in_err : assert property (@(posedge clk) disable iff (!rst_n)
    err_trans_valid |-> !bus_resp_valid_i)
    else $error("Bus response collides with MPU error response");

  a_err_status_state : assert property (@(posedge clk) disable iff (!rst_n)
    err_trans_valid |-> bus_idle_i)
    else $error("MPU error response while bus responses are pending");

  // With nothing pending the error answer follows one cycle later
  a_err_resp_latency : assert property (@(posedge clk) disable iff (!rst_n)
    (core_accept && pma_err_i && bus_idle_i) |=>
      (core_resp_valid_o && (core_resp_o.mpu_status == MPU_ERR)))
    else $error("Error response not given one cycle after acceptance");

endmodule

`default_nettype wire

// File: hw/pma_lookup.sv
// PMA region lookup with lowest-index priority
// Access check for execute, misaligned and atomic accesses
`timescale 1ns/1ps
`default_nettype none
`include "mpu_settings.svh"

module pma_lookup (
  // Only the assertions sample on these
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          addr_i,
  input  logic                 atomic_i,
  input  logic                 execute_i,
  input  logic                 misaligned_i,
  output mpu_pkg::pma_region_t pma_cfg_o,
  output logic                 pma_err_o
);
  import mpu_pkg::*;

  // Built from the settings header, one entry per region
  localparam pma_region_t PMA_TABLE [`MPU_NUM_REGIONS] = '{
    {`MPU_REGION_0_LOW, `MPU_REGION_0_HIGH, `MPU_REGION_0_ATTR},
    {`MPU_REGION_1_LOW, `MPU_REGION_1_HIGH, `MPU_REGION_1_ATTR},
    {`MPU_REGION_2_LOW, `MPU_REGION_2_HIGH, `MPU_REGION_2_ATTR},
    {`MPU_REGION_3_LOW, `MPU_REGION_3_HIGH, `MPU_REGION_3_ATTR}
  };

  logic [29:0] word_addr;
  logic        match_found;
  logic        table_attr_ok;

  assign word_addr = addr_i[31:2];

  // Scan from the top so the lowest matching index is written last
  always_comb begin
    pma_cfg_o   = PMA_R_DEFAULT;
    match_found = 1'b0;
    for (int i = `MPU_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= PMA_TABLE[i].word_addr_low) &&
          (word_addr <  PMA_TABLE[i].word_addr_high)) begin
        pma_cfg_o   = PMA_TABLE[i];
        match_found = 1'b1;
      end
    end
  end

  // Execute and misaligned need main memory, atomics need atomic support
  assign pma_err_o = ((execute_i || misaligned_i) && !pma_cfg_o.main) ||
                     (atomic_i && !pma_cfg_o.atomic);

  ////////////////////
  // Assertions
  ////////////////////

  // Atomics only in main memory, and I/O is never cacheable
  always_comb begin
    table_attr_ok = 1'b1;
    for (int i = 0; i < `MPU_NUM_REGIONS; i++) begin
      if (PMA_TABLE[i].atomic && !PMA_TABLE[i].main) begin
        table_attr_ok = 1'b0;
      end
      if (!PMA_TABLE[i].main && PMA_TABLE[i].cacheable) begin
        table_attr_ok = 1'b0;
      end
    end
  end

  a_table_attr : assert property (@(posedge clk) disable iff (!rst_n) table_attr_ok)
    else $error("PMA table has an illegal attribute combination");

  a_match_bounds : assert property (@(posedge clk) disable iff (!rst_n)
    match_found |-> ((word_addr >= pma_cfg_o.word_addr_low) &&
                     (word_addr <  pma_cfg_o.word_addr_high)))
    else $error("Selected PMA region does not contain the address");

endmodule

`default_nettype wire

// File: hw/mpu_pkg.sv
// Types shared by the MPU blocks
// PMA region, core and bus transactions, responses and FSM states
`default_nettype none

package mpu_pkg;

  ////////////////////
  // PMA regions
  ////////////////////

  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  // Attributes for an address outside every region, plain I/O
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low:  30'h0,
    word_addr_high: 30'h0,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0,
    atomic:         1'b0
  };

  ////////////////////
  // Transactions
  ////////////////////

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        atomic;
    logic        execute;
    logic        misaligned;
  } core_trans_t;

  // Memtype bit 0 is bufferable and bit 1 is cacheable
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [1:0]  memtype;
  } bus_trans_t;

  ////////////////////
  // Responses
  ////////////////////

  typedef enum logic {
    MPU_OK  = 1'b0,
    MPU_ERR = 1'b1
  } mpu_status_e;

  typedef struct packed {
    logic [31:0] rdata;
    logic        bus_err;
    mpu_status_e mpu_status;
  } core_resp_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_resp_t;

  // Error response sequencing
  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_WAIT_BUS = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

endpackage

`default_nettype wire

// File: hw/mpu_settings.svh
// Fixed PMA region table for the data-side MPU
// Outstanding-response limit of the OBI master
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

`define MPU_NUM_REGIONS 4

// Bounds are word addresses with low inclusive and high exclusive
// Attribute bits are ordered {main, bufferable, cacheable, atomic}

// Region 0 covers bytes 0x0000_0000 up to 0x0000_2000
`define MPU_REGION_0_LOW  30'h0000_0000
`define MPU_REGION_0_HIGH 30'h0000_0800
`define MPU_REGION_0_ATTR 4'b1111

// Region 1 covers bytes 0x0000_1000 up to 0x0000_4000 and overlaps region 0
`define MPU_REGION_1_LOW  30'h0000_0400
`define MPU_REGION_1_HIGH 30'h0000_1000
`define MPU_REGION_1_ATTR 4'b1100

// Region 2 is bufferable I/O at bytes 0x0001_0000 up to 0x0001_1000
`define MPU_REGION_2_LOW  30'h0000_4000
`define MPU_REGION_2_HIGH 30'h0000_4400
`define MPU_REGION_2_ATTR 4'b0100

// Region 3 covers bytes 0x2000_0000 up to 0x2001_0000
`define MPU_REGION_3_LOW  30'h0800_0000
`define MPU_REGION_3_HIGH 30'h0800_4000
`define MPU_REGION_3_ATTR 4'b1011

`define MPU_MAX_OUTSTANDING 2

`endif
